/* src/uart_pkg.sv */
package uart_pkg;

    // register map, byte offsets on the 12-bit APB address
    localparam logic [11:0] addr_data   = 12'h000; // read rx byte, write tx byte
    localparam logic [11:0] addr_status = 12'h004;
    localparam logic [11:0] addr_baud   = 12'h008;
    localparam logic [11:0] addr_ctrl   = 12'h00C;

    // STATUS bit positions
    localparam int st_tx_busy   = 0;
    localparam int st_rx_valid  = 1;
    localparam int st_overrun   = 2; // sticky, write 1 to clear
    localparam int st_frame_err = 3; // sticky, write 1 to clear

    // CTRL bit positions
    localparam int ctrl_loopback = 0;
    localparam int ctrl_irq_en   = 1;

    // baud divisor in clk cycles per bit
    localparam int baud_div_w = 16;
    localparam logic [baud_div_w-1:0] baud_div_reset = 16'd5208; // 9600 baud from 50 MHz
    localparam logic [baud_div_w-1:0] baud_div_min   = 16'd4;

    // frame layout: one start bit, data LSB first, one stop bit
    localparam int data_bits  = 8;
    localparam int frame_bits = data_bits + 2;

    // receiver FSM encoding
    localparam logic [1:0] rx_st_idle  = 2'd0;
    localparam logic [1:0] rx_st_start = 2'd1; // waiting for mid start bit
    localparam logic [1:0] rx_st_data  = 2'd2;
    localparam logic [1:0] rx_st_stop  = 2'd3;

endpackage

/* src/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            trmt,     // one-cycle start request
    input  logic [uart_pkg::data_bits-1:0]  tx_data,  // valid with trmt
    input  logic [uart_pkg::baud_div_w-1:0] baud_div, // clk cycles per bit
    output logic                            tx,
    output logic                            tx_busy
);

    logic                            busy_nxt;
    logic                            load;
    logic                            shift;
    logic                            last_bit;
    logic [uart_pkg::data_bits:0]    shft_reg; // byte plus start bit
    logic [uart_pkg::baud_div_w-1:0] baud_cnt;
    logic [3:0]                      bit_cnt;

    // ones are shifted in behind the frame, so the line rests high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shft_reg <= '1;
        end else if (load) begin
            shft_reg <= {tx_data, 1'b0}; // start bit goes out first
        end else if (shift) begin
            shft_reg <= {1'b1, shft_reg[uart_pkg::data_bits:1]};
        end
    end

    assign tx = shft_reg[0];

    // baud counter, restarted at every bit boundary
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt <= '0;
        end else if (load || shift) begin
            baud_cnt <= '0;
        end else if (tx_busy) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    assign shift = tx_busy && (baud_cnt == baud_div - 1'b1);

    // counts bits already sent in this frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= '0;
        end else if (load) begin
            bit_cnt <= '0;
        end else if (shift) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // tenth shift ends the stop bit
    assign last_bit = shift && (bit_cnt == 4'(uart_pkg::frame_bits - 1));

    // two states: idle (tx_busy low) and sending (tx_busy high)
    always_comb begin
        busy_nxt = tx_busy;
        load     = 1'b0;
        if (!tx_busy) begin
            if (trmt) begin
                busy_nxt = 1'b1;
                load     = 1'b1;
            end
        end else if (last_bit) begin
            busy_nxt = 1'b0; // back to idle right at the end of the stop bit
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_busy <= 1'b0;
        end else begin
            tx_busy <= busy_nxt;
        end
    end

endmodule

/* src/uart_rx.sv */
`timescale 1ns/1ps

module uart_rx (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            rxd,      // asynchronous serial input
    input  logic [uart_pkg::baud_div_w-1:0] baud_div,
    output logic [uart_pkg::data_bits-1:0]  rx_byte,
    output logic                            rx_strobe,
    output logic                            rx_frame_err
);

    logic                            rx_meta;
    logic                            rx_sync;
    logic                            rx_prev;  // for falling edge detect
    logic                            fall;
    logic                            mid_start;
    logic                            bit_done;
    logic [1:0]                      state;
    logic [uart_pkg::baud_div_w-1:0] baud_cnt;
    logic [uart_pkg::baud_div_w-1:0] half_div;
    logic [2:0]                      bit_cnt;
    logic [uart_pkg::data_bits-1:0]  shft_reg;

    // two-flop synchronizer plus one stage of history
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rxd;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall      = rx_prev && !rx_sync;
    assign half_div  = {1'b0, baud_div[uart_pkg::baud_div_w-1:1]};
    assign mid_start = (baud_cnt == half_div - 1'b1);
    assign bit_done  = (baud_cnt == baud_div - 1'b1); // one full period from last sample

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= uart_pkg::rx_st_idle;
            baud_cnt     <= '0;
            bit_cnt      <= '0;
            rx_strobe    <= 1'b0;
            rx_frame_err <= 1'b0;
        end else begin
            rx_strobe <= 1'b0;
            case (state)
                uart_pkg::rx_st_idle: begin
                    baud_cnt <= '0;
                    if (fall) begin
                        state <= uart_pkg::rx_st_start;
                    end
                end
                uart_pkg::rx_st_start: begin
                    if (mid_start) begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        // a glitch that is high again at mid-bit is not a start
                        state    <= rx_sync ? uart_pkg::rx_st_idle : uart_pkg::rx_st_data;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::rx_st_data: begin
                    if (bit_done) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'(uart_pkg::data_bits - 1)) begin
                            state <= uart_pkg::rx_st_stop;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                uart_pkg::rx_st_stop: begin
                    if (bit_done) begin
                        baud_cnt     <= '0;
                        rx_strobe    <= 1'b1;
                        rx_frame_err <= !rx_sync; // stop bit must be high
                        state        <= uart_pkg::rx_st_idle;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= uart_pkg::rx_st_idle;
            endcase
        end
    end

    // data path, LSB arrives first so shift right
    always_ff @(posedge clk) begin
        if (state == uart_pkg::rx_st_data && bit_done) begin
            shft_reg <= {rx_sync, shft_reg[uart_pkg::data_bits-1:1]};
        end
        if (state == uart_pkg::rx_st_stop && bit_done) begin
            rx_byte <= shft_reg;
        end
    end

endmodule

/* src/uart_apb_regs.sv */
`timescale 1ns/1ps

module uart_apb_regs (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [11:0]                     paddr,
    input  logic [31:0]                     pwdata,
    output logic [31:0]                     prdata,
    output logic                            pready,
    output logic                            pslverr,
    output logic                            trmt,
    output logic [uart_pkg::data_bits-1:0]  tx_data,
    input  logic                            tx_busy,
    input  logic [uart_pkg::data_bits-1:0]  rx_byte,
    input  logic                            rx_strobe,
    input  logic                            rx_frame_err,
    output logic [uart_pkg::baud_div_w-1:0] baud_div,
    output logic                            loopback,
    output logic                            irq
);

    logic                           access;
    logic                           wr_en;
    logic                           rd_en;
    logic                           addr_hit;
    logic                           tx_full;   // transmitter cannot take a byte
    logic                           baud_low;
    logic                           wr_data;
    logic                           wr_status;
    logic                           wr_baud;
    logic                           wr_ctrl;
    logic                           rd_data;
    logic                           rx_valid;
    logic                           overrun;
    logic                           frame_err;
    logic                           irq_en;
    logic [uart_pkg::data_bits-1:0] rx_data_q;

    assign pready = 1'b1; // no wait states

    assign access   = psel && penable;
    assign wr_en    = access && pwrite;
    assign rd_en    = access && !pwrite;
    assign addr_hit = (paddr == uart_pkg::addr_data) || (paddr == uart_pkg::addr_status)
                   || (paddr == uart_pkg::addr_baud) || (paddr == uart_pkg::addr_ctrl);
    assign tx_full  = tx_busy || trmt; // trmt covers the cycle before tx_busy rises
    assign baud_low = (pwdata[uart_pkg::baud_div_w-1:0] < uart_pkg::baud_div_min);

    assign wr_data   = wr_en && (paddr == uart_pkg::addr_data) && !tx_full;
    assign wr_status = wr_en && (paddr == uart_pkg::addr_status);
    assign wr_baud   = wr_en && (paddr == uart_pkg::addr_baud) && !baud_low;
    assign wr_ctrl   = wr_en && (paddr == uart_pkg::addr_ctrl);
    assign rd_data   = rd_en && (paddr == uart_pkg::addr_data);

    // error response, only in the access phase
    assign pslverr = access && (!addr_hit
                   || (pwrite && (paddr == uart_pkg::addr_data) && tx_full)
                   || (pwrite && (paddr == uart_pkg::addr_baud) && baud_low));

    // read mux
    always_comb begin
        prdata = '0;
        case (paddr)
            uart_pkg::addr_data: prdata[uart_pkg::data_bits-1:0] = rx_data_q;
            uart_pkg::addr_status: begin
                prdata[uart_pkg::st_tx_busy]   = tx_full;
                prdata[uart_pkg::st_rx_valid]  = rx_valid;
                prdata[uart_pkg::st_overrun]   = overrun;
                prdata[uart_pkg::st_frame_err] = frame_err;
            end
            uart_pkg::addr_baud: prdata[uart_pkg::baud_div_w-1:0] = baud_div;
            uart_pkg::addr_ctrl: begin
                prdata[uart_pkg::ctrl_loopback] = loopback;
                prdata[uart_pkg::ctrl_irq_en]   = irq_en;
            end
            default: prdata = '0;
        endcase
    end

    // config registers and transmit request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_div <= uart_pkg::baud_div_reset;
            loopback <= 1'b0;
            irq_en   <= 1'b0;
            trmt     <= 1'b0;
        end else begin
            trmt <= wr_data; // one-cycle pulse after the write completes
            if (wr_baud) begin
                baud_div <= pwdata[uart_pkg::baud_div_w-1:0];
            end
            if (wr_ctrl) begin
                loopback <= pwdata[uart_pkg::ctrl_loopback];
                irq_en   <= pwdata[uart_pkg::ctrl_irq_en];
            end
        end
    end

    // holding registers for both directions
    always_ff @(posedge clk) begin
        if (wr_data) begin
            tx_data <= pwdata[uart_pkg::data_bits-1:0];
        end
        if (rx_strobe) begin
            rx_data_q <= rx_byte; // a new byte always replaces the old one
        end
    end

    // receive status, a new byte wins over a read or a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_valid  <= 1'b0;
            overrun   <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            if (rx_strobe) begin
                rx_valid <= 1'b1;
            end else if (rd_data) begin
                rx_valid <= 1'b0;
            end
            if (rx_strobe && rx_valid && !rd_data) begin
                overrun <= 1'b1; // previous byte was never read
            end else if (wr_status && pwdata[uart_pkg::st_overrun]) begin
                overrun <= 1'b0;
            end
            if (rx_strobe && rx_frame_err) begin
                frame_err <= 1'b1;
            end else if (wr_status && pwdata[uart_pkg::st_frame_err]) begin
                frame_err <= 1'b0;
            end
        end
    end

    assign irq = irq_en && rx_valid;

endmodule

/* src/uart_top.sv */
`timescale 1ns/1ps

module uart_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    input  logic        rxd,
    output logic        tx,
    output logic        irq
);

    logic                            trmt;
    logic [uart_pkg::data_bits-1:0]  tx_data;
    logic                            tx_busy;
    logic [uart_pkg::data_bits-1:0]  rx_byte;
    logic                            rx_strobe;
    logic                            rx_frame_err;
    logic [uart_pkg::baud_div_w-1:0] baud_div;
    logic                            loopback;
    logic                            rx_in;

    uart_apb_regs u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .trmt         (trmt),
        .tx_data      (tx_data),
        .tx_busy      (tx_busy),
        .rx_byte      (rx_byte),
        .rx_strobe    (rx_strobe),
        .rx_frame_err (rx_frame_err),
        .baud_div     (baud_div),
        .loopback     (loopback),
        .irq          (irq)
    );

    uart_tx u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .trmt     (trmt),
        .tx_data  (tx_data),
        .baud_div (baud_div),
        .tx       (tx),
        .tx_busy  (tx_busy)
    );

    // loopback feeds the transmitter straight back, the rx pin is ignored then
    assign rx_in = loopback ? tx : rxd;

    uart_rx u_rx (
        .clk          (clk),
        .rst_n        (rst_n),
        .rxd          (rx_in),
        .baud_div     (baud_div),
        .rx_byte      (rx_byte),
        .rx_strobe    (rx_strobe),
        .rx_frame_err (rx_frame_err)
    );

endmodule

/* test/uart_properties.sv */
`timescale 1ns/1ps

module uart_properties (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic tx,
    input logic tx_busy,
    input logic trmt
);

    int fail_cnt = 0; // failed assertions so far

    // access phase only inside a selected transfer
    penable_needs_psel: assert property (@(posedge clk) disable iff (!rst_n)
        penable |-> psel)
        else begin
            fail_cnt++;
            $error("penable high without psel");
        end

    idle_line_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> tx)
        else begin
            fail_cnt++;
            $error("tx low while the transmitter is idle");
        end

    // start bit follows the request by one cycle
    start_after_trmt: assert property (@(posedge clk) disable iff (!rst_n)
        trmt |=> !tx)
        else begin
            fail_cnt++;
            $error("no start bit on the cycle after trmt");
        end

endmodule

bind uart_top uart_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .tx      (tx),
    .tx_busy (tx_busy),
    .trmt    (trmt)
);

/* test/tb_uart.sv */
`timescale 1ns/1ps

module tb_uart;

    localparam int tx_div         = 16;             // divisor used by every serial test
    localparam int frame_cycles   = 10 * tx_div;
    localparam int timeout_cycles = 20 * frame_cycles + 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        rxd;
    logic        tx;
    logic        irq;

    integer seed = 32'hf6b4;
    int     cycles = 0;
    int     errors = 0;
    int     errors_at_start = 0;
    int     assert_fails_seen = 0;
    int     tests_run = 0;
    int     tests_failed = 0;

    uart_top u_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input logic [31:0] actual,
                                   input logic [31:0] expected);
        errors++;
        $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
    endtask

    task automatic finish_test(input string name);
        int new_fails;
        new_fails = u_dut.u_props.fail_cnt - assert_fails_seen; // bound assertions
        errors += new_fails;
        assert_fails_seen += new_fails;
        tests_run++;
        if (errors == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - errors_at_start);
        end
    endtask

    // one APB transfer with a setup and an access cycle
    task automatic apb_access(input logic write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] data,
                              output logic slverr);
        @(posedge clk);
        psel   <= 1'b1;
        pwrite <= write;
        paddr  <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk); // response sampled in the middle of the access cycle
        data   = prdata;
        slverr = pslverr;
        if (pready !== 1'b1) report_mismatch("pready", pready, 32'h1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata,
                             output logic slverr);
        logic [31:0] unused;
        apb_access(1'b1, addr, wdata, unused, slverr);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic slverr);
        apb_access(1'b0, addr, 32'h0, data, slverr);
    endtask

    // polls STATUS until the masked bits match or the poll limit runs out
    task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                               input string what);
        logic [31:0] st;
        logic        slverr;
        int          polls;
        polls = 0;
        apb_read(uart_pkg::addr_status, st, slverr);
        while ((st & mask) !== value && polls < frame_cycles) begin
            apb_read(uart_pkg::addr_status, st, slverr);
            polls++;
        end
        if ((st & mask) !== value) begin
            errors++;
            $display("Timed out at %0t ns waiting for %s", $time, what);
        end
    endtask

    // decodes one frame on tx with each bit sampled near its middle
    task automatic monitor_tx_frame(input int div, output logic [7:0] data);
        int wait_cnt;
        wait_cnt = 0;
        data     = '0;
        @(negedge clk);
        while (tx !== 1'b0 && wait_cnt < frame_cycles) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (tx !== 1'b0) begin
            errors++;
            $display("No start bit appeared on tx by %0t ns", $time);
        end else begin
            repeat (div / 2) @(negedge clk);
            if (tx !== 1'b0) report_mismatch("tx in the middle of the start bit", tx, 32'h0);
            for (int i = 0; i < uart_pkg::data_bits; i++) begin
                repeat (div) @(negedge clk);
                data[i] = tx; // LSB first
            end
            repeat (div) @(negedge clk);
            if (tx !== 1'b1) report_mismatch("tx in the middle of the stop bit", tx, 32'h1);
        end
    endtask

    task automatic drive_rx_frame(input int div, input logic [7:0] data, input logic stop);
        logic [9:0] frame;
        frame = {stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (div - 1) @(posedge clk);
        end
        @(posedge clk);
        rxd <= 1'b1; // line back to idle after a bad stop bit
    endtask

    task automatic reset_state();
        logic [31:0] d;
        logic        e;
        errors_at_start = errors;
        apb_read(uart_pkg::addr_status, d, e);
        if (d !== 32'h0) report_mismatch("STATUS after reset", d, 32'h0);
        apb_read(uart_pkg::addr_baud, d, e);
        if (d !== 32'd5208) report_mismatch("BAUD after reset", d, 32'd5208);
        apb_read(uart_pkg::addr_ctrl, d, e);
        if (d !== 32'h0) report_mismatch("CTRL after reset", d, 32'h0);
        if (tx !== 1'b1) report_mismatch("tx after reset", tx, 32'h1);
        if (irq !== 1'b0) report_mismatch("irq after reset", irq, 32'h0);
        finish_test("reset_state");
    endtask

    task automatic transmit_bytes();
        logic [31:0] d;
        logic        e;
        logic        e_rd;
        logic [7:0]  b;
        logic [7:0]  got;
        errors_at_start = errors;
        apb_write(uart_pkg::addr_baud, tx_div, e);
        if (e !== 1'b0) report_mismatch("pslverr on BAUD write", e, 32'h0);
        repeat (4) begin
            b = $random(seed);
            apb_write(uart_pkg::addr_data, {24'h0, b}, e);
            if (e !== 1'b0) report_mismatch("pslverr on DATA write", e, 32'h0);
            fork
                monitor_tx_frame(tx_div, got);
                begin
                    apb_read(uart_pkg::addr_status, d, e_rd);
                    if (d[uart_pkg::st_tx_busy] !== 1'b1) begin
                        report_mismatch("STATUS tx_busy during a frame", d, 32'h1);
                    end
                    if (e_rd !== 1'b0) report_mismatch("pslverr on STATUS read", e_rd, 32'h0);
                end
            join
            if (got !== b) report_mismatch("byte decoded from tx", got, b);
            wait_status(32'h1 << uart_pkg::st_tx_busy, 32'h0, "tx_busy to clear");
        end
        finish_test("transmit");
    endtask

    task automatic refused_writes();
        logic [31:0] d;
        logic        e;
        logic        e_busy;
        logic [7:0]  b;
        logic [7:0]  got;
        int          low_cnt;
        errors_at_start = errors;
        low_cnt = 0;
        b = $random(seed);
        apb_write(uart_pkg::addr_data, {24'h0, b}, e);
        fork
            monitor_tx_frame(tx_div, got);
            apb_write(uart_pkg::addr_data, {24'h0, ~b}, e_busy);
        join
        if (e_busy !== 1'b1) report_mismatch("pslverr on DATA write while busy", e_busy, 32'h1);
        if (got !== b) report_mismatch("byte decoded from tx", got, b);
        wait_status(32'h1 << uart_pkg::st_tx_busy, 32'h0, "tx_busy to clear");
        repeat (2 * tx_div) begin
            @(negedge clk);
            if (tx !== 1'b1) low_cnt++; // a second frame would pull the line low
        end
        if (low_cnt != 0) report_mismatch("tx low samples after the frame", low_cnt, 32'h0);
        apb_write(uart_pkg::addr_baud, 32'd3, e);
        if (e !== 1'b1) report_mismatch("pslverr on BAUD write of 3", e, 32'h1);
        apb_read(uart_pkg::addr_baud, d, e);
        if (d !== tx_div) report_mismatch("BAUD after refused write", d, tx_div);
        apb_write(12'h010, 32'h5a, e);
        if (e !== 1'b1) report_mismatch("pslverr on unmapped write", e, 32'h1);
        apb_read(12'h010, d, e);
        if (e !== 1'b1) report_mismatch("pslverr on unmapped read", e, 32'h1);
        finish_test("refusal");
    endtask

    task automatic receive_bytes();
        logic [31:0] d;
        logic        e;
        logic [7:0]  b;
        int          wait_cnt;
        errors_at_start = errors;
        apb_write(uart_pkg::addr_ctrl, 32'h1 << uart_pkg::ctrl_irq_en, e);
        repeat (3) begin
            b = $random(seed);
            drive_rx_frame(tx_div, b, 1'b1);
            wait_cnt = 0;
            while (irq !== 1'b1 && wait_cnt < frame_cycles) begin
                @(negedge clk);
                wait_cnt++;
            end
            if (irq !== 1'b1) report_mismatch("irq after a received frame", irq, 32'h1);
            apb_read(uart_pkg::addr_status, d, e);
            if (d !== (32'h1 << uart_pkg::st_rx_valid)) begin
                report_mismatch("STATUS after a received frame", d, 32'h1 << uart_pkg::st_rx_valid);
            end
            apb_read(uart_pkg::addr_data, d, e);
            if (d !== {24'h0, b}) report_mismatch("DATA read", d, {24'h0, b});
            apb_read(uart_pkg::addr_status, d, e);
            if (d !== 32'h0) report_mismatch("STATUS after DATA read", d, 32'h0);
            if (irq !== 1'b0) report_mismatch("irq after DATA read", irq, 32'h0);
        end
        apb_write(uart_pkg::addr_ctrl, 32'h0, e);
        finish_test("receive");
    endtask

    task automatic error_flags();
        logic [31:0] d;
        logic [31:0] flags;
        logic        e;
        logic [7:0]  b;
        errors_at_start = errors;
        flags = (32'h1 << uart_pkg::st_overrun) | (32'h1 << uart_pkg::st_frame_err);
        b = $random(seed);
        drive_rx_frame(tx_div, b, 1'b1);
        b = $random(seed);
        drive_rx_frame(tx_div, b, 1'b1);   // first byte still unread
        wait_status(32'h1 << uart_pkg::st_overrun, 32'h1 << uart_pkg::st_overrun, "overrun");
        apb_read(uart_pkg::addr_status, d, e);
        if (d !== 32'h6) report_mismatch("STATUS after overrun", d, 32'h6);
        b = $random(seed);
        drive_rx_frame(tx_div, b, 1'b0);   // stop bit low
        wait_status(32'h1 << uart_pkg::st_frame_err, 32'h1 << uart_pkg::st_frame_err,
                    "frame error");
        apb_read(uart_pkg::addr_status, d, e);
        if (d !== 32'he) report_mismatch("STATUS after framing error", d, 32'he);
        apb_write(uart_pkg::addr_status, flags, e);
        apb_read(uart_pkg::addr_status, d, e);
        if (d !== 32'h2) report_mismatch("STATUS after clearing flags", d, 32'h2);
        apb_read(uart_pkg::addr_data, d, e);
        if (d !== {24'h0, b}) report_mismatch("DATA after errors", d, {24'h0, b});
        apb_read(uart_pkg::addr_status, d, e);
        if (d !== 32'h0) report_mismatch("STATUS at end of error test", d, 32'h0);
        finish_test("errors");
    endtask

    task automatic loopback_bytes();
        logic [31:0] d;
        logic        e;
        logic [7:0]  b;
        errors_at_start = errors;
        apb_write(uart_pkg::addr_ctrl, 32'h1 << uart_pkg::ctrl_loopback, e);
        repeat (4) begin
            b = $random(seed);
            apb_write(uart_pkg::addr_data, {24'h0, b}, e);
            wait_status(32'h1 << uart_pkg::st_tx_busy, 32'h0, "tx_busy to clear");
            apb_read(uart_pkg::addr_status, d, e);
            if (d !== 32'h2) report_mismatch("STATUS after loopback frame", d, 32'h2);
            apb_read(uart_pkg::addr_data, d, e);
            if (d !== {24'h0, b}) report_mismatch("looped back byte", d, {24'h0, b});
        end
        apb_write(uart_pkg::addr_ctrl, 32'h0, e);
        finish_test("loopback");
    endtask

    initial begin
        rst_n   = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rxd     = 1'b1; // idle line
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        reset_state();
        transmit_bytes();
        refused_writes();
        receive_bytes();
        error_flags();
        loopback_bytes();
        $display("tests run: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
                 tests_run, tests_failed, errors, assert_fails_seen);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_apb_regs.sv
src/uart_top.sv
test/uart_properties.sv
test/tb_uart.sv

/* Bender.yml */
package:
  name: uart_apb

sources:
  - src/uart_pkg.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/uart_apb_regs.sv
  - src/uart_top.sv
  - target: test
    files:
      - test/uart_properties.sv
      - test/tb_uart.sv
